/* Makefile */
# Verilator build and run of the execution unit testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check the log for the pass message"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f tb.f \
		--top-module tb_execution_unit -Mdir obj_dir
	./obj_dir/Vtb_execution_unit | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* bench/eu_checker.sv */
module eu_checker
(
    input  logic clk,
    input  logic reset,
    input  eu_pkg::bus_cmd_e bus_command,
    input  logic [eu_pkg::ADDR_W-1:0] bus_address,
    input  logic [eu_pkg::DATA_W-1:0] data_out,
    input  logic bus_command_done
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int DRAIN_LIMIT = 2000;

    // expected bus operations of the running test, oldest first
    eu_pkg::bus_cmd_e exp_cmd [$];
    logic [eu_pkg::ADDR_W-1:0] exp_addr [$];
    logic [eu_pkg::DATA_W-1:0] exp_data [$];

    string test_name;
    int test_errors;
    int tests_passed;
    int tests_failed;

    // set once the current request has been compared
    logic seen;

    initial
    begin
        test_name    = "none";
        test_errors  = 0;
        tests_passed = 0;
        tests_failed = 0;
    end

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic expect_op(input eu_pkg::bus_cmd_e cmd,
                             input logic [eu_pkg::ADDR_W-1:0] addr,
                             input logic [eu_pkg::DATA_W-1:0] data);
        exp_cmd.push_back(cmd);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic check_value(input string sig, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("CHECK FAILED %s got %h expected %h (test %s)",
                     sig, got, exp, test_name);
            test_errors++;
        end
    endtask

    task automatic note_error(input string what);
        $display("ERROR in test %s: %s", test_name, what);
        test_errors++;
    endtask

    // waits until every expected operation was seen and the bus is idle
    task automatic finish_test;
        int waited;
        waited = 0;
        while ((exp_cmd.size() != 0 || bus_command != eu_pkg::IDLE) && waited < DRAIN_LIMIT)
        begin
            @(posedge clk);
            waited++;
        end
        if (waited >= DRAIN_LIMIT)
            note_error("timed out waiting for the expected bus operations");
        if (test_errors == 0)
        begin
            $display("test %s: PASS", test_name);
            tests_passed++;
        end
        else
        begin
            $display("test %s: FAIL with %0d errors", test_name, test_errors);
            tests_failed++;
        end
    endtask

    task automatic report_totals;
        $display("tests run %0d, pass %0d, fail %0d",
                 tests_passed + tests_failed, tests_passed, tests_failed);
    endtask

    // compare each new request once, at the first edge it is visible
    always @(posedge clk)
    begin
        if (reset)
        begin
            seen <= 1'b0;
        end
        else if (bus_command != eu_pkg::IDLE)
        begin
            if (!seen)
            begin
                if (exp_cmd.size() == 0)
                begin
                    note_error("bus operation issued that no test expects");
                end
                else
                begin
                    check_value("bus_command", bus_command, exp_cmd[0]);
                    check_value("bus_address", bus_address, exp_addr[0]);
                    // read data comes from the responder, only stores are checked
                    if (exp_cmd[0] == eu_pkg::WRITE)
                        check_value("data_out", data_out, exp_data[0]);
                    void'(exp_cmd.pop_front());
                    void'(exp_addr.pop_front());
                    void'(exp_data.pop_front());
                end
                seen <= 1'b1;
            end
            if (bus_command_done)
                seen <= 1'b0;
        end
    end

endmodule

/* bench/eu_stim.txt */
# test <name>, seg <es> <cs> <ss> <ds>, q <queue bytes in hex>
# then R|W <address> <data> per bus operation in order, end closes the test
test imm_store
seg 0000 0000 2000 1000
q b8 34 12 89 06 00 01 b4 ab 89 06 02 01 b1 5c 88 0e 04 01 88 26 05 01
W 10100 1234
W 10102 ab34
W 10104 005c
W 10105 00ab
end
test load_disp8
seg 0000 0000 2000 1000
q bb 00 02 be 30 00 8b 40 f0 89 06 10 00 8a 50 02 88 16 12 00
R 10220 beef
W 10010 beef
R 10232 77c3
W 10012 00c3
end
test imm_mem_bp
seg 0000 f000 3000 1000
q bd 00 01 c7 86 34 12 cd ab c6 46 fe 5a
W 31334 abcd
W 300fe 005a
end
test sreg
seg 4000 f000 3000 1000
q 8c 06 20 00 8c d9 89 0e 22 00 8c 1e 24 00
W 10020 4000
W 10022 1000
W 10024 1000
end
test unknown_op
seg 4000 f000 3000 1000
q b8 11 22 f4 89 06 30 00 90 88 26 32 00
W 10030 2211
W 10032 0022
end

/* bench/tb_execution_unit.sv */
module tb_execution_unit;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 16;
    localparam int QUEUE_LIMIT  = 3000;
    localparam int RUN_LIMIT    = 100000;

    logic clk;
    logic reset;
    logic [eu_pkg::BYTE_W-1:0] prefetch_data;
    logic queue_empty;
    logic queue_pop;
    logic [eu_pkg::DATA_W-1:0] segment_registers [eu_pkg::NUM_SREGS];
    eu_pkg::bus_cmd_e bus_command;
    logic [eu_pkg::ADDR_W-1:0] bus_address;
    logic [eu_pkg::DATA_W-1:0] data_out;
    logic [eu_pkg::DATA_W-1:0] data_in;
    logic bus_command_done;

    integer seed = 24;

    // bytes still to hand to the fetch stage, and data for upcoming reads
    logic [eu_pkg::BYTE_W-1:0] byte_q [$];
    logic [eu_pkg::DATA_W-1:0] read_q [$];

    // responder: 0 idle, 1 counting down, 2 done pulse out
    int resp_state;
    int resp_delay;

    execution_unit DUT
    (
        .clk(clk),
        .reset(reset),
        .prefetch_data(prefetch_data),
        .queue_empty(queue_empty),
        .queue_pop(queue_pop),
        .segment_registers(segment_registers),
        .bus_command(bus_command),
        .bus_address(bus_address),
        .data_out(data_out),
        .data_in(data_in),
        .bus_command_done(bus_command_done)
    );

    eu_checker monitor
    (
        .clk(clk),
        .reset(reset),
        .bus_command(bus_command),
        .bus_address(bus_address),
        .data_out(data_out),
        .bus_command_done(bus_command_done)
    );

    initial
    begin
        clk = 1'b0;
        reset = 1'b1;
        prefetch_data = '0;
        queue_empty = 1'b1;
        data_in = '0;
        bus_command_done = 1'b0;
        for (int i = 0; i < eu_pkg::NUM_SREGS; i++)
            segment_registers[i] = '0;
    end

    always #4 clk = ~clk;

    // queue model, random gaps of about one cycle in four
    always @(posedge clk)
    begin
        if (reset)
        begin
            // a byte is on offer during reset and must stay untaken
            queue_empty   <= 1'b0;
            prefetch_data <= 8'hb8;
        end
        else
        begin
            if (queue_pop && byte_q.size() > 0)
                void'(byte_q.pop_front());
            if (byte_q.size() == 0 || ($unsigned($random(seed)) % 4) == 0)
            begin
                queue_empty <= 1'b1;
            end
            else
            begin
                queue_empty   <= 1'b0;
                prefetch_data <= byte_q[0];
            end
        end
    end

    // bus responder, 0 to 5 cycles before done
    always @(posedge clk)
    begin
        if (reset)
        begin
            resp_state       <= 0;
            bus_command_done <= 1'b0;
        end
        else
        begin
            case (resp_state)
                0:
                begin
                    bus_command_done <= 1'b0;
                    if (bus_command != eu_pkg::IDLE)
                    begin
                        resp_delay <= $unsigned($random(seed)) % 6;
                        resp_state <= 1;
                    end
                end
                1:
                begin
                    if (resp_delay == 0)
                    begin
                        bus_command_done <= 1'b1;
                        if (bus_command == eu_pkg::READ && read_q.size() > 0)
                            data_in <= read_q.pop_front();
                        resp_state <= 2;
                    end
                    else
                    begin
                        resp_delay <= resp_delay - 1;
                    end
                end
                default:
                begin
                    // command drops to IDLE on this edge
                    bus_command_done <= 1'b0;
                    resp_state       <= 0;
                end
            endcase
        end
    end

    // hard stop in case some wait never ends
    initial
    begin
        int cycles;
        cycles = 0;
        while (cycles < RUN_LIMIT)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("simulation ran past its cycle limit");
        $display("Some tests failed");
        $finish;
    end

    initial
    begin
        int fd;
        int waited;
        string tok;
        string name;
        string rest;
        logic [eu_pkg::DATA_W-1:0] seg_val [eu_pkg::NUM_SREGS];
        logic [eu_pkg::ADDR_W-1:0] addr;
        logic [eu_pkg::DATA_W-1:0] data;
        logic [eu_pkg::BYTE_W-1:0] one_byte;
        logic [eu_pkg::BYTE_W-1:0] pending_bytes [$];

        // reset phase, outputs quiet while reset is held
        monitor.begin_test("reset");
        for (int c = 0; c < RESET_CYCLES; c++)
        begin
            @(posedge clk);
            // release on the last reset edge
            if (c == RESET_CYCLES - 1)
                reset <= 1'b0;
            #1;
            monitor.check_value("bus_command", bus_command, eu_pkg::IDLE);
            monitor.check_value("queue_pop", queue_pop, 1'b0);
        end
        monitor.finish_test();

        fd = $fopen("bench/eu_stim.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the stimulus file bench/eu_stim.txt");
            $display("Some tests failed");
            $finish;
        end
        else
        begin
            while ($fscanf(fd, "%s", tok) == 1)
            begin
                if (tok == "#")
                begin
                    void'($fgets(rest, fd));
                end
                else if (tok == "test")
                begin
                    void'($fscanf(fd, "%s", name));
                    monitor.begin_test(name);
                end
                else if (tok == "seg")
                begin
                    for (int i = 0; i < eu_pkg::NUM_SREGS; i++)
                        void'($fscanf(fd, "%h", seg_val[i]));
                    @(posedge clk);
                    for (int i = 0; i < eu_pkg::NUM_SREGS; i++)
                        segment_registers[i] <= seg_val[i];
                end
                else if (tok == "q")
                begin
                    pending_bytes.delete();
                end
                else if (tok == "R" || tok == "W")
                begin
                    void'($fscanf(fd, "%h %h", addr, data));
                    if (tok == "R")
                    begin
                        monitor.expect_op(eu_pkg::READ, addr, data);
                        read_q.push_back(data);
                    end
                    else
                    begin
                        monitor.expect_op(eu_pkg::WRITE, addr, data);
                    end
                end
                else if (tok == "end")
                begin
                    @(posedge clk);
                    foreach (pending_bytes[i])
                        byte_q.push_back(pending_bytes[i]);
                    waited = 0;
                    while (byte_q.size() != 0 && waited < QUEUE_LIMIT)
                    begin
                        @(posedge clk);
                        waited++;
                    end
                    if (waited >= QUEUE_LIMIT)
                        monitor.note_error("queue bytes were not consumed in time");
                    monitor.finish_test();
                end
                else
                begin
                    // anything else is a queue byte in hex
                    void'($sscanf(tok, "%h", one_byte));
                    pending_bytes.push_back(one_byte);
                end
            end
            $fclose(fd);

            monitor.report_totals();
            if (monitor.tests_failed == 0)
                $display("All tests passed");
            else
                $display("Some tests failed");
            $finish;
        end
    end

endmodule

/* src/byte_fetch.sv */
module byte_fetch
(
    input  logic clk,
    input  logic reset,
    input  logic [eu_pkg::BYTE_W-1:0] prefetch_data,
    input  logic queue_empty,
    output logic queue_pop,
    instr_if.fetch instr
);

    eu_pkg::fetch_state_e state;
    eu_pkg::fetch_state_e step;

    // held from the cycle after reset
    logic running;
    logic slot_free;
    logic load;

    // assembly registers, one per instruction byte
    logic [eu_pkg::BYTE_W-1:0] opcode_q, modrm_q, disp_lo_q, disp_hi_q, imm_lo_q, imm_hi_q;
    logic [eu_pkg::BYTE_W-1:0] opcode_n, modrm_n, disp_lo_n, disp_hi_n, imm_lo_n, imm_hi_n;
    logic [eu_pkg::DATA_W-1:0] disp_full;
    logic [eu_pkg::DATA_W-1:0] imm_full;

    logic need_modrm, need_disp, disp_word, need_imm, imm_word, dec_word;
    eu_pkg::mov_kind_e dec_kind;
    logic [2:0] dec_reg_id;

    // FULL holds a finished instruction, nothing more is popped
    assign queue_pop = running && !queue_empty && (state != eu_pkg::FULL);

    // the byte on prefetch_data lands in the field of the current state
    assign opcode_n  = (queue_pop && state == eu_pkg::OPCODE)  ? prefetch_data : opcode_q;
    assign modrm_n   = (queue_pop && state == eu_pkg::MODRM)   ? prefetch_data : modrm_q;
    assign disp_lo_n = (queue_pop && state == eu_pkg::DISP_LO) ? prefetch_data : disp_lo_q;
    assign disp_hi_n = (queue_pop && state == eu_pkg::DISP_HI) ? prefetch_data : disp_hi_q;
    assign imm_lo_n  = (queue_pop && state == eu_pkg::IMM_LO)  ? prefetch_data : imm_lo_q;
    assign imm_hi_n  = (queue_pop && state == eu_pkg::IMM_HI)  ? prefetch_data : imm_hi_q;

    // decode sees the byte arriving now, so the next field is known at once
    mov_decode decode_inst
    (
        .opcode(opcode_n),
        .modrm(modrm_n),
        .need_modrm(need_modrm),
        .need_disp(need_disp),
        .disp_word(disp_word),
        .need_imm(need_imm),
        .imm_word(imm_word),
        .word(dec_word),
        .kind(dec_kind),
        .reg_id(dec_reg_id)
    );

    // disp8 is sign-extended, missing disp reads as zero for the adder
    assign disp_full = !need_disp ? '0 :
                       disp_word  ? {disp_hi_n, disp_lo_n} :
                                    {{eu_pkg::BYTE_W{disp_lo_n[7]}}, disp_lo_n};
    assign imm_full  = imm_word ? {imm_hi_n, imm_lo_n} : {{eu_pkg::BYTE_W{1'b0}}, imm_lo_n};

    // which field follows the current one, FULL marks the last byte
    always_comb
    begin
        step = eu_pkg::FULL;
        case (state)
            eu_pkg::OPCODE:
                step = need_modrm ? eu_pkg::MODRM : need_imm ? eu_pkg::IMM_LO : eu_pkg::FULL;
            eu_pkg::MODRM:
                step = need_disp ? eu_pkg::DISP_LO : need_imm ? eu_pkg::IMM_LO : eu_pkg::FULL;
            eu_pkg::DISP_LO:
                step = disp_word ? eu_pkg::DISP_HI : need_imm ? eu_pkg::IMM_LO : eu_pkg::FULL;
            eu_pkg::DISP_HI:
                step = need_imm ? eu_pkg::IMM_LO : eu_pkg::FULL;
            eu_pkg::IMM_LO:
                step = imm_word ? eu_pkg::IMM_HI : eu_pkg::FULL;
            default:
                step = eu_pkg::FULL;
        endcase
    end

    // slot can accept when empty or emptied on this edge
    assign slot_free = !instr.valid || instr.take;
    assign load = (queue_pop && step == eu_pkg::FULL && slot_free)
               || (state == eu_pkg::FULL && instr.take);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            running     <= 1'b0;
            state       <= eu_pkg::OPCODE;
            instr.valid <= 1'b0;
        end
        else
        begin
            running <= 1'b1;
            if (load)
            begin
                instr.valid <= 1'b1;
            end
            else if (instr.take)
            begin
                instr.valid <= 1'b0;
            end

            if (load)
            begin
                state <= eu_pkg::OPCODE;
            end
            else if (queue_pop)
            begin
                // last byte with a busy slot parks in FULL
                state <= step;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        opcode_q  <= opcode_n;
        modrm_q   <= modrm_n;
        disp_lo_q <= disp_lo_n;
        disp_hi_q <= disp_hi_n;
        imm_lo_q  <= imm_lo_n;
        imm_hi_q  <= imm_hi_n;
    end

    // present the instruction to execute
    always_ff @(posedge clk)
    begin
        if (load)
        begin
            instr.kind   <= dec_kind;
            instr.word   <= dec_word;
            instr.modrm  <= modrm_n;
            instr.disp   <= disp_full;
            instr.imm    <= imm_full;
            instr.reg_id <= dec_reg_id;
        end
    end

    // a finished instruction only parks behind a busy slot
    assert property (@(posedge clk) disable iff (reset) state == eu_pkg::FULL |-> instr.valid);

endmodule

/* src/ea_calc.sv */
module ea_calc
(
    input  logic [eu_pkg::BYTE_W-1:0] modrm,
    input  logic [eu_pkg::DATA_W-1:0] disp,
    input  logic [eu_pkg::DATA_W-1:0] bw,
    input  logic [eu_pkg::DATA_W-1:0] bp,
    input  logic [eu_pkg::DATA_W-1:0] ix,
    input  logic [eu_pkg::DATA_W-1:0] iy,
    input  logic [eu_pkg::DATA_W-1:0] segment_registers [eu_pkg::NUM_SREGS],
    output logic [eu_pkg::ADDR_W-1:0] physical_address
);

    logic [eu_pkg::DATA_W-1:0] base;
    logic [eu_pkg::DATA_W-1:0] offset;
    logic [eu_pkg::DATA_W-1:0] segment;
    logic mod_zero;
    logic bp_based;

    assign mod_zero = (modrm[7:6] == 2'b00);

    always_comb
    begin
        case (modrm[2:0])
            3'd0: base = bw + ix;
            3'd1: base = bw + iy;
            3'd2: base = bp + ix;
            3'd3: base = bp + iy;
            3'd4: base = ix;
            3'd5: base = iy;
            // direct address when mod is 00, disp carries it
            3'd6: base = mod_zero ? '0 : bp;
            default: base = bw;
        endcase
    end

    // 16-bit wrap on the offset
    assign offset = base + disp;

    // BP forms address the stack segment
    assign bp_based = (modrm[2:1] == 2'b01) || (modrm[2:0] == 3'd6 && !mod_zero);
    assign segment  = bp_based ? segment_registers[eu_pkg::SREG_SS]
                               : segment_registers[eu_pkg::SREG_DS];

    assign physical_address = {segment, 4'h0} + {4'h0, offset};

endmodule

/* src/eu_pkg.sv */
package eu_pkg;

    // datapath widths
    localparam int DATA_W = 16;
    localparam int ADDR_W = 20;
    localparam int BYTE_W = 8;

    // register counts
    localparam int NUM_REGS  = 8;
    localparam int NUM_SREGS = 4;

    // segment indices, order ES CS SS DS
    localparam logic [1:0] SREG_SS = 2'd2;
    localparam logic [1:0] SREG_DS = 2'd3;

    // word registers used by address generation
    // order AW CW DW BW SP BP IX IY
    localparam logic [2:0] REG_BW = 3'd3;
    localparam logic [2:0] REG_BP = 3'd5;
    localparam logic [2:0] REG_IX = 3'd6;
    localparam logic [2:0] REG_IY = 3'd7;

    // opcode patterns without the size bit
    localparam logic [6:0] OPC_MOV_RM_R   = 7'b1000100;
    localparam logic [6:0] OPC_MOV_R_RM   = 7'b1000101;
    localparam logic [6:0] OPC_MOV_RM_IMM = 7'b1100011;
    // 8C has no size bit, 8D is a different instruction
    localparam logic [7:0] OPC_MOV_RM_SREG = 8'h8C;
    // B0..BF, size in bit 3 and register in bits 2:0
    localparam logic [3:0] OPC_MOV_REG_IMM = 4'b1011;

    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        READ  = 2'd1,
        WRITE = 2'd2
    } bus_cmd_e;

    typedef enum logic [2:0] {
        MOV_NONE,
        MOV_REG_FROM_RM,
        MOV_RM_FROM_REG,
        MOV_RM_FROM_IMM,
        MOV_REG_FROM_IMM,
        MOV_RM_FROM_SREG
    } mov_kind_e;

    typedef enum logic [2:0] {
        OPCODE,
        MODRM,
        DISP_LO,
        DISP_HI,
        IMM_LO,
        IMM_HI,
        FULL
    } fetch_state_e;

endpackage

/* src/execution_unit.sv */
module execution_unit
(
    input  logic clk,
    input  logic reset,

    // prefetch queue
    input  logic [eu_pkg::BYTE_W-1:0] prefetch_data,
    input  logic queue_empty,
    output logic queue_pop,

    // segment values from the bus unit
    input  logic [eu_pkg::DATA_W-1:0] segment_registers [eu_pkg::NUM_SREGS],

    // bus
    output eu_pkg::bus_cmd_e bus_command,
    output logic [eu_pkg::ADDR_W-1:0] bus_address,
    output logic [eu_pkg::DATA_W-1:0] data_out,
    input  logic [eu_pkg::DATA_W-1:0] data_in,
    input  logic bus_command_done
);

    // one decoded instruction between the stages
    instr_if instr_bus ();

    byte_fetch fetch_inst
    (
        .clk(clk),
        .reset(reset),
        .prefetch_data(prefetch_data),
        .queue_empty(queue_empty),
        .queue_pop(queue_pop),
        .instr(instr_bus.fetch)
    );

    mov_execute exec_inst
    (
        .clk(clk),
        .reset(reset),
        .instr(instr_bus.exec),
        .segment_registers(segment_registers),
        .bus_command(bus_command),
        .bus_address(bus_address),
        .data_out(data_out),
        .data_in(data_in),
        .bus_command_done(bus_command_done)
    );

endmodule

/* src/instr_if.sv */
interface instr_if;

    // instruction present, fields stable while high
    logic valid;
    eu_pkg::mov_kind_e kind;
    // operand size, 1 for word
    logic word;
    logic [eu_pkg::BYTE_W-1:0] modrm;
    // already sign-extended for disp8, zero when absent
    logic [eu_pkg::DATA_W-1:0] disp;
    logic [eu_pkg::DATA_W-1:0] imm;
    // modrm reg field, or opcode register for B0..BF
    logic [2:0] reg_id;
    // one-cycle pulse from execute when it is done with the instruction
    logic take;

    modport fetch
    (
        output valid, kind, word, modrm, disp, imm, reg_id,
        input  take
    );

    modport exec
    (
        input  valid, kind, word, modrm, disp, imm, reg_id,
        output take
    );

endinterface

/* src/mov_decode.sv */
module mov_decode
(
    input  logic [eu_pkg::BYTE_W-1:0] opcode,
    input  logic [eu_pkg::BYTE_W-1:0] modrm,
    output logic need_modrm,
    output logic need_disp,
    output logic disp_word,
    output logic need_imm,
    output logic imm_word,
    output logic word,
    output eu_pkg::mov_kind_e kind,
    output logic [2:0] reg_id
);

    logic [1:0] mod;
    logic [2:0] rm;
    logic direct;

    assign mod = modrm[7:6];
    assign rm  = modrm[2:0];

    // mod 00 with rm 110 is a bare 16-bit address
    assign direct = (mod == 2'b00) && (rm == 3'b110);

    // displacement only exists behind a modrm byte
    assign need_disp = need_modrm && ((mod == 2'b01) || (mod == 2'b10) || direct);
    assign disp_word = (mod == 2'b10) || direct;

    always_comb
    begin
        // unknown opcodes fall through as a one-byte no-op
        kind       = eu_pkg::MOV_NONE;
        need_modrm = 1'b0;
        need_imm   = 1'b0;
        imm_word   = 1'b0;
        word       = opcode[0];
        reg_id     = modrm[5:3];

        if (opcode[7:1] == eu_pkg::OPC_MOV_RM_R)
        begin
            kind       = eu_pkg::MOV_RM_FROM_REG;
            need_modrm = 1'b1;
        end
        else if (opcode[7:1] == eu_pkg::OPC_MOV_R_RM)
        begin
            kind       = eu_pkg::MOV_REG_FROM_RM;
            need_modrm = 1'b1;
        end
        else if (opcode[7:1] == eu_pkg::OPC_MOV_RM_IMM)
        begin
            kind       = eu_pkg::MOV_RM_FROM_IMM;
            need_modrm = 1'b1;
            need_imm   = 1'b1;
            imm_word   = opcode[0];
        end
        else if (opcode == eu_pkg::OPC_MOV_RM_SREG)
        begin
            // segment registers are always word sized
            kind       = eu_pkg::MOV_RM_FROM_SREG;
            need_modrm = 1'b1;
            word       = 1'b1;
        end
        else if (opcode[7:4] == eu_pkg::OPC_MOV_REG_IMM)
        begin
            // short form, register in the opcode itself
            kind     = eu_pkg::MOV_REG_FROM_IMM;
            need_imm = 1'b1;
            imm_word = opcode[3];
            word     = opcode[3];
            reg_id   = opcode[2:0];
        end
    end

endmodule

/* src/mov_execute.sv */
module mov_execute
(
    input  logic clk,
    input  logic reset,
    instr_if.exec instr,
    input  logic [eu_pkg::DATA_W-1:0] segment_registers [eu_pkg::NUM_SREGS],
    output eu_pkg::bus_cmd_e bus_command,
    output logic [eu_pkg::ADDR_W-1:0] bus_address,
    output logic [eu_pkg::DATA_W-1:0] data_out,
    input  logic [eu_pkg::DATA_W-1:0] data_in,
    input  logic bus_command_done
);

    logic uses_rm;
    logic is_mem;
    logic mem_read;
    logic reg_dest;
    logic pending;
    logic bus_done;
    logic issue;

    logic rf_we;
    logic [2:0] rf_write_id;
    logic [2:0] rf_read_id;
    logic [eu_pkg::DATA_W-1:0] rf_read_data;
    logic [eu_pkg::DATA_W-1:0] addr_regs [4];

    logic [eu_pkg::DATA_W-1:0] load_data;
    logic [eu_pkg::DATA_W-1:0] src_data;
    logic [eu_pkg::DATA_W-1:0] store_data;
    logic [eu_pkg::ADDR_W-1:0] physical_address;

    // kinds with an rm operand, memory unless mod is 11
    assign uses_rm = (instr.kind == eu_pkg::MOV_REG_FROM_RM)
                  || (instr.kind == eu_pkg::MOV_RM_FROM_REG)
                  || (instr.kind == eu_pkg::MOV_RM_FROM_IMM)
                  || (instr.kind == eu_pkg::MOV_RM_FROM_SREG);
    assign is_mem   = uses_rm && (instr.modrm[7:6] != 2'b11);
    assign mem_read = is_mem && (instr.kind == eu_pkg::MOV_REG_FROM_RM);
    assign reg_dest = (instr.kind == eu_pkg::MOV_REG_FROM_RM)
                   || (instr.kind == eu_pkg::MOV_REG_FROM_IMM)
                   || (uses_rm && !is_mem);

    assign pending  = (bus_command != eu_pkg::IDLE);
    assign bus_done = pending && bus_command_done;
    assign issue    = instr.valid && is_mem && !pending;

    // register moves retire at once, memory moves with the bus answer
    assign instr.take = instr.valid && (!is_mem || bus_done);
    assign rf_we = instr.take && reg_dest;

    // reg field for the 88/89 source, rm field otherwise
    assign rf_read_id = (instr.kind == eu_pkg::MOV_RM_FROM_REG) ? instr.reg_id
                                                                : instr.modrm[2:0];
    assign rf_write_id = ((instr.kind == eu_pkg::MOV_REG_FROM_RM)
                       || (instr.kind == eu_pkg::MOV_REG_FROM_IMM)) ? instr.reg_id
                                                                    : instr.modrm[2:0];

    // byte loads keep the low byte only
    assign load_data = instr.word ? data_in
                                  : {{eu_pkg::BYTE_W{1'b0}}, data_in[eu_pkg::BYTE_W-1:0]};

    always_comb
    begin
        case (instr.kind)
            eu_pkg::MOV_REG_FROM_IMM,
            eu_pkg::MOV_RM_FROM_IMM:  src_data = instr.imm;
            eu_pkg::MOV_RM_FROM_SREG: src_data = segment_registers[instr.reg_id[1:0]];
            eu_pkg::MOV_REG_FROM_RM:  src_data = is_mem ? load_data : rf_read_data;
            default:                  src_data = rf_read_data;
        endcase
    end

    // byte stores go out on the low lane, high lane zero
    assign store_data = instr.word ? src_data
                                   : {{eu_pkg::BYTE_W{1'b0}}, src_data[eu_pkg::BYTE_W-1:0]};

    ea_calc ea_inst
    (
        .modrm(instr.modrm),
        .disp(instr.disp),
        .bw(addr_regs[0]),
        .bp(addr_regs[1]),
        .ix(addr_regs[2]),
        .iy(addr_regs[3]),
        .segment_registers(segment_registers),
        .physical_address(physical_address)
    );

    register_file register_file_inst
    (
        .clk(clk),
        .reset(reset),
        .we(rf_we),
        .word(instr.word),
        .write_id(rf_write_id),
        .write_data(src_data),
        .read_id(rf_read_id),
        .read_data(rf_read_data),
        .addr_regs(addr_regs)
    );

    // command stays up until done, then idles for at least a cycle
    always_ff @(posedge clk)
    begin
        if (reset)
            bus_command <= eu_pkg::IDLE;
        else if (bus_done)
            bus_command <= eu_pkg::IDLE;
        else if (issue)
            bus_command <= mem_read ? eu_pkg::READ : eu_pkg::WRITE;
    end

    always_ff @(posedge clk)
    begin
        if (issue)
        begin
            bus_address <= physical_address;
            data_out    <= store_data;
        end
    end

    // a pending request belongs to the memory move still presented
    assert property (@(posedge clk) disable iff (reset)
        pending |-> instr.valid && is_mem);

    // and its address matches that operand until done
    assert property (@(posedge clk) disable iff (reset)
        pending |-> bus_address == physical_address);

endmodule

/* src/register_file.sv */
module register_file
(
    input  logic clk,
    input  logic reset,
    input  logic we,
    input  logic word,
    input  logic [2:0] write_id,
    input  logic [eu_pkg::DATA_W-1:0] write_data,
    input  logic [2:0] read_id,
    output logic [eu_pkg::DATA_W-1:0] read_data,
    // BW, BP, IX, IY in that order
    output logic [eu_pkg::DATA_W-1:0] addr_regs [4]
);

    localparam int HI = eu_pkg::DATA_W - 1;
    localparam int LO_TOP = eu_pkg::BYTE_W - 1;

    logic [eu_pkg::DATA_W-1:0] regs [eu_pkg::NUM_REGS];
    logic [eu_pkg::DATA_W-1:0] read_word;

    // byte ids 4..7 are the high halves of registers 0..3
    assign read_word = regs[{1'b0, read_id[1:0]}];
    assign read_data = word        ? regs[read_id] :
                       read_id[2]  ? {{eu_pkg::BYTE_W{1'b0}}, read_word[HI:eu_pkg::BYTE_W]} :
                                     {{eu_pkg::BYTE_W{1'b0}}, read_word[LO_TOP:0]};

    assign addr_regs[0] = regs[eu_pkg::REG_BW];
    assign addr_regs[1] = regs[eu_pkg::REG_BP];
    assign addr_regs[2] = regs[eu_pkg::REG_IX];
    assign addr_regs[3] = regs[eu_pkg::REG_IY];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < eu_pkg::NUM_REGS; i++)
                regs[i] <= '0;
        end
        else if (we)
        begin
            if (word)
                regs[write_id] <= write_data;
            // a byte write only touches its lane
            else if (write_id[2])
                regs[{1'b0, write_id[1:0]}][HI:eu_pkg::BYTE_W] <= write_data[LO_TOP:0];
            else
                regs[{1'b0, write_id[1:0]}][LO_TOP:0] <= write_data[LO_TOP:0];
        end
    end

endmodule

/* tb.f */
src/eu_pkg.sv
src/instr_if.sv
src/mov_decode.sv
src/ea_calc.sv
src/register_file.sv
src/byte_fetch.sv
src/mov_execute.sv
src/execution_unit.sv
bench/eu_checker.sv
bench/tb_execution_unit.sv
